//--- Bender.yml
package:
  name: pwl_wave_gen

sources:
  # Design, in compile order
  - design/pwl_pkg.sv
  - design/pwl_interpolator.sv
  - design/pwl_line_packer.sv
  - design/pwl_line_ram.sv
  - design/pwl_playback.sv
  - design/pwl_wave_gen.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - bench/pwl_wave_gen_sva.sv
      - bench/pwl_wave_gen_tb.sv

//--- bench/pwl_wave_gen_sva.sv
`timescale 1ns/10ps

module pwl_wave_gen_sva #(
	parameter int LINE_DEPTH = 16,
	parameter int LINE_W     = 64
) (
	input logic                        clk,
	input logic                        rst,
	input logic                        halt,
	input logic                        run,
	input logic                        dac_rdy,
	input logic                        batch_valid,
	input logic [LINE_W-1:0]           batch_data,
	input logic [$clog2(LINE_DEPTH):0] line_count
);

	// Player leaves reset with nothing on offer
	a_idle_after_reset: assert property (@(posedge clk) rst |=> !batch_valid)
		else $error("batch_valid high in the cycle after reset");

	// Offered line holds under back-pressure
	a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
		batch_valid && !dac_rdy && run && !halt |=> batch_valid && $stable(batch_data))
		else $error("batch_valid or batch_data changed while dac_rdy was low");

	a_count_range: assert property (@(posedge clk) disable iff (rst) line_count <= LINE_DEPTH)
		else $error("line_count exceeds the line memory depth");

endmodule

bind pwl_wave_gen pwl_wave_gen_sva #(
	.LINE_DEPTH (LINE_DEPTH),
	.LINE_W     (BATCH_SAMPLES * pwl_pkg::SAMPLE_WIDTH)
) i_sva (
	.clk         (clk),
	.rst         (rst),
	.halt        (halt),
	.run         (run),
	.dac_rdy     (dac_rdy),
	.batch_valid (batch_valid),
	.batch_data  (batch_data),
	.line_count  (line_count)
);

//--- bench/pwl_wave_gen_tb.sv
`timescale 1ns/10ps

module pwl_wave_gen_tb;
	import pwl_pkg::*;

	localparam int  BATCH_SAMPLES = 4;
	localparam int  LINE_DEPTH    = 16;
	localparam int  MAX_BP        = 8;
	localparam int  N_WAVES       = 5;
	localparam int  PLAY_N        = 24;  // Enough for two full loops
	localparam int  PLAY_TOTAL    = 4 * PLAY_N + 5;
	localparam real WATCHDOG_NS   = 3.0 * 40.0 * (N_WAVES * (64 + MAX_BP) + PLAY_TOTAL * 4);

	typedef logic [$clog2(LINE_DEPTH):0]           count_t;
	typedef logic [BATCH_SAMPLES*SAMPLE_WIDTH-1:0] line_t;

	logic   clk, rst, halt, run, dac_rdy;
	logic   bp_valid, bp_last, bp_ready, batch_valid;
	bp_t    bp_data;
	line_t  batch_data;
	count_t line_count;

	integer  seed;
	int      sample_errors, count_errors, proto_errors;
	int      n_bp, n_smp, exp_lines;
	int      bp_time [MAX_BP];
	sample_t bp_smp [MAX_BP];
	slope_t  bp_slope [MAX_BP];
	sample_t exp_smp [64];  // One reference sample per sample period

	pwl_wave_gen #(.BATCH_SAMPLES(BATCH_SAMPLES), .LINE_DEPTH(LINE_DEPTH)) i_dut (.*);

	always #20 clk = ~clk;

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	// ========================================
	// Reference model and compare tasks
	// ========================================
	function automatic void build_model();
		sample_t v;
		n_smp = bp_time[n_bp-1] + 1;
		for (int k = 0; k < n_bp - 1; k++) begin
			for (int t = bp_time[k]; t < bp_time[k+1]; t++) begin
				v = sample_t'(int'(bp_smp[k]) + (t - bp_time[k]) * int'(bp_slope[k]));
				if (bp_slope[k] >= 0) begin
					if (v > bp_smp[k+1]) begin
						v = bp_smp[k+1];  // Stop at the end point
					end
				end else if (v < bp_smp[k+1]) begin
					v = bp_smp[k+1];
				end
				exp_smp[t] = v;
			end
		end
		exp_smp[n_smp-1] = bp_smp[n_bp-1];
		exp_lines = (n_smp + BATCH_SAMPLES - 1) / BATCH_SAMPLES;
	endfunction

	function automatic sample_t exp_slot(input int line, input int slot);
		int s;
		s = line * BATCH_SAMPLES + slot;
		return (s < n_smp) ? exp_smp[s] : exp_smp[n_smp-1];  // Pad with the last sample
	endfunction

	task automatic check_sample(input sample_t got, input sample_t exp,
			input int line, input int slot);
		if (got !== exp) begin
			sample_errors++;
			$display("[ERROR] %0t ns batch_data line %0d slot %0d: got %0d, expected %0d",
				$time, line, slot, got, exp);
		end
	endtask

	task automatic check_lines(input count_t got, input count_t exp);
		if (got !== exp) begin
			count_errors++;
			$display("[ERROR] %0t ns line_count: got %0d, expected %0d", $time, got, exp);
		end
	endtask

	// ========================================
	// Stimulus
	// ========================================
	task automatic load_wave(input bit mixed, input int halt_at);
		int n_send;
		n_bp = (halt_at != 0) ? MAX_BP : 2 + rand_below(MAX_BP - 1);
		for (int k = 0; k < n_bp; k++) begin
			bp_time[k] = (k == 0) ? 0 : bp_time[k-1] + 1 + rand_below(6);
			if (mixed) begin
				bp_smp[k]   = sample_t'(rand_below(2001) - 1000);
				bp_slope[k] = slope_t'(rand_below(801) - 400);  // Often overshoots
			end else begin
				bp_smp[k]   = (k == 0) ? sample_t'(rand_below(1000)) :
					bp_smp[k-1] + sample_t'(rand_below(801));
				bp_slope[k] = slope_t'(rand_below(201));
			end
		end
		n_send = (halt_at != 0) ? halt_at : n_bp;
		for (int k = 0; k < n_send; k++) begin
			repeat (1 + rand_below(3)) next_cycle();
			bp_valid = 1'b1;
			bp_data  = {time_t'(bp_time[k]), bp_smp[k], bp_slope[k]};
			bp_last  = (k == n_bp - 1);
			@(negedge clk);
			while (!bp_ready) @(negedge clk);
			next_cycle();
			bp_valid = 1'b0;
		end
		if (halt_at != 0) begin
			halt = 1'b1;  // Abort while a segment is being emitted
			next_cycle();
			halt = 1'b0;
			check_lines(line_count, exp_lines);
			return;
		end
		@(negedge clk);
		while (!bp_ready) @(negedge clk);
		next_cycle();
		next_cycle();
		build_model();
		check_lines(line_count, exp_lines);
	endtask

	task automatic play_lines(input int n_lines, input bit stall);
		int idx;
		int got;
		idx = 0;
		got = 0;
		next_cycle();
		run     = 1'b1;
		dac_rdy = 1'b1;
		next_cycle();
		next_cycle();
		@(negedge clk);
		if (!batch_valid) begin
			proto_errors++;
			$display("Error at %0t ns: batch_valid did not rise two cycles after run", $time);
		end
		while (got < n_lines) begin
			if (batch_valid && dac_rdy) begin
				for (int s = 0; s < BATCH_SAMPLES; s++) begin
					check_sample(batch_data[s*SAMPLE_WIDTH +: SAMPLE_WIDTH], exp_slot(idx, s), idx, s);
				end
				idx = (idx + 1) % exp_lines;  // Loop wrap
				got++;
			end
			next_cycle();
			dac_rdy = stall ? (rand_below(4) != 0) : 1'b1;
			@(negedge clk);
		end
	endtask

	task automatic stop_run();
		next_cycle();
		run = 1'b0;
		next_cycle();
		@(negedge clk);
		if (batch_valid) begin
			proto_errors++;
			$display("Error at %0t ns: batch_valid still high after run was dropped", $time);
		end
	endtask

	initial begin
		seed = 32'h3ec63da2;
		{clk, halt, run, dac_rdy, bp_valid, bp_last} = '0;
		bp_data = '0;
		rst = 1'b1;
		{sample_errors, count_errors, proto_errors, exp_lines} = '0;
		repeat (3) next_cycle();
		rst = 1'b0;

		load_wave(1'b0, 0);  // Rising wave with the DAC always ready
		play_lines(PLAY_N, 1'b0);
		stop_run();

		load_wave(1'b1, 0);  // Clamped segments under back-pressure
		play_lines(PLAY_N, 1'b1);
		next_cycle();
		halt = 1'b1;  // run stays high so only halt can stop the player
		next_cycle();
		halt = 1'b0;
		run  = 1'b0;
		@(negedge clk);
		if (batch_valid) begin
			proto_errors++;
			$display("Error at %0t ns: batch_valid still high after halt", $time);
		end
		check_lines(line_count, exp_lines);
		play_lines(5, 1'b1);  // Must restart at line 0
		stop_run();

		load_wave(1'b1, 2);  // Halted load followed by a full one
		load_wave(1'b1, 0);
		play_lines(PLAY_N, 1'b1);
		stop_run();

		load_wave(1'b1, 0);
		play_lines(PLAY_N, 1'b0);
		stop_run();

		$display("Error counts: samples %0d, line_count %0d, protocol %0d",
			sample_errors, count_errors, proto_errors);
		if (sample_errors + count_errors + proto_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog timeout: test sequence still running after %0.0f ns", WATCHDOG_NS);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- design/pwl_interpolator.sv
`timescale 1ns/10ps

module pwl_interpolator (
	input  logic             clk,
	input  logic             rst,
	input  logic             halt,
	input  logic             bp_valid,
	input  logic             bp_last,
	input  pwl_pkg::bp_t     bp_data,
	output logic             bp_ready,
	output logic             smp_valid,
	output logic             smp_last,
	output pwl_pkg::sample_t smp_data
);
	import pwl_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_HAVE_FIRST,
		S_EMIT,
		S_FINAL
	} state_t;

	state_t state;

	// Unpacked breakpoint fields
	sample_t in_sample;
	slope_t  in_slope;
	time_t   in_time;

	// Segment start point
	sample_t cur_sample;
	slope_t  cur_slope;
	time_t   cur_time;

	// Segment end point
	sample_t nxt_sample;
	slope_t  nxt_slope;
	time_t   nxt_time;
	logic    nxt_last;  // End point closes the wave

	time_t   seg_off;   // t minus time_k
	time_t   seg_len;
	sample_t lin_val;
	sample_t clamp_val;
	logic    bp_take;

	assign in_slope  = bp_data[BP_SLOPE_LSB +: SAMPLE_WIDTH];
	assign in_sample = bp_data[BP_SAMPLE_LSB +: SAMPLE_WIDTH];
	assign in_time   = bp_data[BP_TIME_LSB +: TIME_WIDTH];

	assign bp_ready = (state == S_IDLE) || (state == S_HAVE_FIRST);  // Held off during a segment
	assign bp_take  = bp_valid && bp_ready;
	assign seg_len  = nxt_time - cur_time;

	// Linear term wraps to 16 bits, then stops at the end point
	always_comb begin
		lin_val = cur_sample + sample_t'(seg_off * cur_slope);
		if (!cur_slope[SAMPLE_WIDTH-1]) begin
			clamp_val = (lin_val > nxt_sample) ? nxt_sample : lin_val;
		end else begin
			clamp_val = (lin_val < nxt_sample) ? nxt_sample : lin_val;
		end
	end

	assign smp_valid = (state == S_EMIT) || (state == S_FINAL);
	assign smp_last  = (state == S_FINAL);
	assign smp_data  = (state == S_FINAL) ? nxt_sample : clamp_val;

	always_ff @(posedge clk) begin
		if (rst || halt) begin
			state    <= S_IDLE;
			seg_off  <= '0;
			nxt_last <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (bp_take) begin
						cur_sample <= in_sample;
						cur_slope  <= in_slope;
						cur_time   <= in_time;
						nxt_sample <= in_sample;  // Lone breakpoint is its own final sample
						state      <= bp_last ? S_FINAL : S_HAVE_FIRST;
					end
				end
				S_HAVE_FIRST: begin
					if (bp_take) begin
						nxt_sample <= in_sample;
						nxt_slope  <= in_slope;
						nxt_time   <= in_time;
						nxt_last   <= bp_last;
						seg_off    <= '0;
						state      <= S_EMIT;
					end
				end
				S_EMIT: begin
					if (seg_off == seg_len - 1'b1) begin
						seg_off <= '0;
						if (nxt_last) begin
							state <= S_FINAL;
						end else begin
							// End point becomes the next start point
							cur_sample <= nxt_sample;
							cur_slope  <= nxt_slope;
							cur_time   <= nxt_time;
							state      <= S_HAVE_FIRST;
						end
					end else begin
						seg_off <= seg_off + 1'b1;
					end
				end
				S_FINAL: state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

//--- design/pwl_line_packer.sv
`timescale 1ns/10ps

module pwl_line_packer #(
	parameter int BATCH_SAMPLES = 4,
	parameter int LINE_DEPTH    = 16
) (
	input  logic                                           clk,
	input  logic                                           rst,
	input  logic                                           halt,
	input  logic                                           smp_valid,
	input  logic                                           smp_last,
	input  pwl_pkg::sample_t                               smp_data,
	output logic                                           wr_en,
	output logic [$clog2(LINE_DEPTH)-1:0]                  wr_addr,
	output logic [BATCH_SAMPLES*pwl_pkg::SAMPLE_WIDTH-1:0] wr_line,
	output logic [$clog2(LINE_DEPTH):0]                    line_count
);
	import pwl_pkg::*;

	localparam int SLOT_W = (BATCH_SAMPLES > 1) ? $clog2(BATCH_SAMPLES) : 1;

	sample_t [BATCH_SAMPLES-1:0] line_buf;  // Slot 0 in the low bits
	logic    [SLOT_W-1:0]        slot;
	logic                        line_full;
	logic                        line_done;
	logic                        wr_last;  // Pending write closes the wave

	assign line_full = (slot == SLOT_W'(BATCH_SAMPLES - 1));
	assign line_done = smp_valid && (line_full || smp_last);
	assign wr_line   = line_buf;

	// ========================================
	// Line assembly
	// ========================================
	// Final sample also fills every slot above it
	always_ff @(posedge clk) begin
		if (smp_valid) begin
			for (int i = 0; i < BATCH_SAMPLES; i++) begin
				if (i == slot || (smp_last && i > slot)) begin
					line_buf[i] <= smp_data;
				end
			end
		end
	end

	// ========================================
	// Write sequencing and line count
	// ========================================
	always_ff @(posedge clk) begin
		if (rst || halt) begin
			slot    <= '0;
			wr_en   <= 1'b0;
			wr_last <= 1'b0;
			wr_addr <= '0;
			if (rst) begin
				line_count <= '0;  // Kept across halt
			end
		end else begin
			wr_en   <= line_done;  // Write goes out one cycle after the last slot
			wr_last <= smp_valid && smp_last;
			if (smp_valid) begin
				slot <= line_done ? '0 : slot + 1'b1;
			end
			if (wr_en) begin
				if (wr_last) begin
					line_count <= {1'b0, wr_addr} + 1'b1;
					wr_addr    <= '0;  // Next wave starts at line 0
				end else begin
					wr_addr <= wr_addr + 1'b1;
				end
			end
		end
	end

endmodule

//--- design/pwl_line_ram.sv
`timescale 1ns/10ps

module pwl_line_ram #(
	parameter int BATCH_SAMPLES = 4,
	parameter int LINE_DEPTH    = 16
) (
	input  logic                                           clk,
	input  logic                                           wr_en,
	input  logic [$clog2(LINE_DEPTH)-1:0]                  wr_addr,
	input  logic [BATCH_SAMPLES*pwl_pkg::SAMPLE_WIDTH-1:0] wr_line,
	input  logic [$clog2(LINE_DEPTH)-1:0]                  rd_addr,
	output logic [BATCH_SAMPLES*pwl_pkg::SAMPLE_WIDTH-1:0] rd_line
);
	import pwl_pkg::*;

	localparam int ADDR_W = $clog2(LINE_DEPTH);
	localparam int LINE_W = BATCH_SAMPLES * SAMPLE_WIDTH;

	logic [LINE_W-1:0] mem [LINE_DEPTH];
	logic [ADDR_W-1:0] port_addr;

	// One port, builder write has priority
	assign port_addr = wr_en ? wr_addr : rd_addr;

	// Registered read, output holds during a write
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[port_addr] <= wr_line;
		end else begin
			rd_line <= mem[port_addr];
		end
	end

endmodule

//--- design/pwl_pkg.sv
package pwl_pkg;

	// ========================================
	// Field widths and types
	// ========================================
	localparam int SAMPLE_WIDTH = 16;
	localparam int TIME_WIDTH   = 16;
	localparam int BP_WIDTH     = TIME_WIDTH + 2 * SAMPLE_WIDTH;

	typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;  // Two's complement DAC code
	typedef logic        [TIME_WIDTH-1:0]   time_t;    // In sample periods
	typedef logic signed [SAMPLE_WIDTH-1:0] slope_t;   // Increment per sample period
	typedef logic        [BP_WIDTH-1:0]     bp_t;

	// ========================================
	// Breakpoint word layout
	// ========================================
	// Slope sits in the low bits, time in the high bits
	localparam int BP_SLOPE_LSB  = 0;
	localparam int BP_SAMPLE_LSB = BP_SLOPE_LSB + SAMPLE_WIDTH;
	localparam int BP_TIME_LSB   = BP_SAMPLE_LSB + SAMPLE_WIDTH;

endpackage

//--- design/pwl_playback.sv
`timescale 1ns/10ps

module pwl_playback #(
	parameter int BATCH_SAMPLES = 4,
	parameter int LINE_DEPTH    = 16
) (
	input  logic                                           clk,
	input  logic                                           rst,
	input  logic                                           halt,
	input  logic                                           run,
	input  logic                                           dac_rdy,
	input  logic [$clog2(LINE_DEPTH):0]                    line_count,
	input  logic [BATCH_SAMPLES*pwl_pkg::SAMPLE_WIDTH-1:0] rd_line,
	output logic [$clog2(LINE_DEPTH)-1:0]                  rd_addr,
	output logic                                           batch_valid,
	output logic [BATCH_SAMPLES*pwl_pkg::SAMPLE_WIDTH-1:0] batch_data
);
	localparam int ADDR_W = $clog2(LINE_DEPTH);

	typedef enum logic [1:0] {
		P_IDLE,
		P_READ_WAIT,
		P_SEND
	} state_t;

	state_t state;

	logic [ADDR_W-1:0] idx;  // Line on offer
	logic [ADDR_W-1:0] idx_next;
	logic              xfer;

	assign batch_valid = (state == P_SEND);
	assign xfer        = batch_valid && dac_rdy;
	assign idx_next    = ({1'b0, idx} == line_count - 1'b1) ? '0 : idx + 1'b1;  // Loop wrap

	// Read ahead on a transfer so the next line is ready one cycle later
	assign rd_addr    = xfer ? idx_next : idx;
	assign batch_data = rd_line;

	// ========================================
	// Playback FSM
	// ========================================
	always_ff @(posedge clk) begin
		if (rst || halt) begin
			state <= P_IDLE;
			idx   <= '0;
		end else begin
			case (state)
				P_IDLE: begin
					idx <= '0;
					if (run && line_count != '0) begin
						state <= P_READ_WAIT;
					end
				end
				// Line 0 is being read
				P_READ_WAIT: state <= run ? P_SEND : P_IDLE;
				P_SEND: begin
					if (!run) begin
						state <= P_IDLE;
					end else if (dac_rdy) begin
						idx <= idx_next;
					end
				end
				default: state <= P_IDLE;
			endcase
		end
	end

endmodule

//--- design/pwl_wave_gen.sv
`timescale 1ns/10ps

module pwl_wave_gen #(
	parameter int BATCH_SAMPLES = 4,
	parameter int LINE_DEPTH    = 16
) (
	input  logic                                           clk,
	input  logic                                           rst,
	input  logic                                           halt,
	input  logic                                           run,
	input  logic                                           bp_valid,
	input  pwl_pkg::bp_t                                   bp_data,
	input  logic                                           bp_last,
	output logic                                           bp_ready,
	input  logic                                           dac_rdy,
	output logic                                           batch_valid,
	output logic [BATCH_SAMPLES*pwl_pkg::SAMPLE_WIDTH-1:0] batch_data,
	output logic [$clog2(LINE_DEPTH):0]                    line_count
);
	import pwl_pkg::*;

	localparam int ADDR_W = $clog2(LINE_DEPTH);
	localparam int LINE_W = BATCH_SAMPLES * SAMPLE_WIDTH;

	// Interpolator to packer
	logic    smp_valid;
	logic    smp_last;
	sample_t smp_data;

	// Line memory ports
	logic              wr_en;
	logic [ADDR_W-1:0] wr_addr;
	logic [LINE_W-1:0] wr_line;
	logic [ADDR_W-1:0] rd_addr;
	logic [LINE_W-1:0] rd_line;

	// ========================================
	// Wave builder
	// ========================================
	pwl_interpolator i_interp (
		.clk       (clk),
		.rst       (rst),
		.halt      (halt),
		.bp_valid  (bp_valid),
		.bp_last   (bp_last),
		.bp_data   (bp_data),
		.bp_ready  (bp_ready),
		.smp_valid (smp_valid),
		.smp_last  (smp_last),
		.smp_data  (smp_data)
	);

	pwl_line_packer #(
		.BATCH_SAMPLES (BATCH_SAMPLES),
		.LINE_DEPTH    (LINE_DEPTH)
	) i_packer (
		.clk        (clk),
		.rst        (rst),
		.halt       (halt),
		.smp_valid  (smp_valid),
		.smp_last   (smp_last),
		.smp_data   (smp_data),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_line    (wr_line),
		.line_count (line_count)
	);

	// ========================================
	// Memory and player
	// ========================================
	pwl_line_ram #(
		.BATCH_SAMPLES (BATCH_SAMPLES),
		.LINE_DEPTH    (LINE_DEPTH)
	) i_ram (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_line (wr_line),
		.rd_addr (rd_addr),
		.rd_line (rd_line)
	);

	pwl_playback #(
		.BATCH_SAMPLES (BATCH_SAMPLES),
		.LINE_DEPTH    (LINE_DEPTH)
	) i_player (
		.clk         (clk),
		.rst         (rst),
		.halt        (halt),
		.run         (run),
		.dac_rdy     (dac_rdy),
		.line_count  (line_count),
		.rd_line     (rd_line),
		.rd_addr     (rd_addr),
		.batch_valid (batch_valid),
		.batch_data  (batch_data)
	);

endmodule

//--- pwl_wave_gen.f
design/pwl_pkg.sv
design/pwl_interpolator.sv
design/pwl_line_packer.sv
design/pwl_line_ram.sv
design/pwl_playback.sv
design/pwl_wave_gen.sv
bench/pwl_wave_gen_sva.sv
bench/pwl_wave_gen_tb.sv
